/* rvfi_trace.f */
+incdir+logic
logic/rvfi_trace_pkg.sv
logic/rvfi_probes.sv
logic/rvfi_port_tracer.sv
logic/trace_write_arbiter.sv
logic/trace_buffer.sv
logic/rvfi_trace_top.sv
tb/rvfi_trace_tb.sv

/* tb/rvfi_trace_tb.sv */
// Retirement trace testbench
// Drives the commit ports, models the expected retire records and checks the trace readback
`timescale 1ns/10ps
`include "rvfi_trace_cfg.svh"
`default_nettype none

module rvfi_trace_tb;

    import rvfi_trace_pkg::*;

    // Sum of 2 + 6 + 3 + 4 + 24 retires over all tests
    localparam int NR_RETIRES  = 39;
    localparam int CYCLE_LIMIT = 10 * NR_RETIRES + 200;
    localparam exception_t NO_EXC = '0;

    logic                                clk;
    logic                                arst_n;
    commit_entry_t [`RVFI_NR_COMMIT-1:0] commit_instr;
    logic [`RVFI_NR_COMMIT-1:0]          commit_ack;
    exception_t                          ex_commit;
    priv_lvl_t                           priv_lvl;
    logic                                debug_mode;
    logic [`RVFI_TRACE_AW-1:0]           rd_addr;
    retire_rec_t                         rd_rec;
    logic [`RVFI_ORDER_W-1:0]            retire_count;
    logic                                overflow;

    // Reference model and read check pipeline
    retire_rec_t              exp_q [$];
    logic [`RVFI_ORDER_W-1:0] exp_order;
    logic                     rd_vld = 1'b0;
    retire_rec_t              rd_exp;
    logic                     chk_vld = 1'b0;
    retire_rec_t              chk_exp;

    logic [31:0] lcg_state;
    int          errors = 0;
    int          reads = 0;
    int          cycles = 0;

    rvfi_trace_top dut0 (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .commit_instr_i (commit_instr),
        .commit_ack_i   (commit_ack),
        .ex_commit_i    (ex_commit),
        .priv_lvl_i     (priv_lvl),
        .debug_mode_i   (debug_mode),
        .rd_addr_i      (rd_addr),
        .rd_rec_o       (rd_rec),
        .retire_count_o (retire_count),
        .overflow_o     (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // Record for an address shows up one cycle after the address
    always @(posedge clk) begin
        chk_vld <= rd_vld;
        chk_exp <= rd_exp;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic commit_entry_t rand_entry(input logic comp, input logic rd_zero);
        commit_entry_t e;
        logic [31:0]   r;
        r               = next_rand();
        e.pc            = {r[31:1], 1'b0};
        // Compressed words keep a nonzero upper half so its zeroing is visible
        e.insn          = comp ? (next_rand() | 32'h0001_0000) : (next_rand() | 32'h3);
        e.is_compressed = comp;
        r               = next_rand();
        e.rd            = rd_zero ? 5'd0 : ((r[4:0] == 5'd0) ? 5'd1 : r[4:0]);
        e.result        = next_rand();
        return e;
    endfunction

    task automatic push_expected(input int p);
        commit_entry_t e;
        retire_rec_t   rec;
        logic          trap;
        e            = commit_instr[p];
        trap         = (p == 0) && ex_commit.valid;
        rec          = '0;
        rec.order    = exp_order;
        rec.pc_rdata = e.pc;
        rec.pc_wdata = e.pc + (e.is_compressed ? 32'd2 : 32'd4);
        rec.insn     = e.is_compressed ? {16'h0000, e.insn[15:0]} : e.insn;
        rec.rd_addr  = e.rd;
        rec.rd_wdata = ((e.rd == 5'd0) || trap) ? '0 : e.result;
        rec.trap     = trap;
        rec.cause    = trap ? ex_commit.cause : 32'h0;
        rec.priv     = priv_lvl;
        rec.dbg      = debug_mode;
        exp_q.push_back(rec);
        exp_order = exp_order + 1;
    endtask

    task automatic commit_cycle(input logic [`RVFI_NR_COMMIT-1:0] ack, input commit_entry_t e0,
                                input commit_entry_t e1, input exception_t ex,
                                input priv_lvl_t priv, input logic dbg);
        @(negedge clk);
        // Every earlier acknowledgment is counted by now
        expect_value("retire_count_o", retire_count, exp_order);
        commit_instr[0] = e0;
        commit_instr[1] = e1;
        commit_ack      = ack;
        ex_commit       = ex;
        priv_lvl        = priv;
        debug_mode      = dbg;
        for (int p = 0; p < `RVFI_NR_COMMIT; p++) begin
            if (ack[p]) begin
                push_expected(p);
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            commit_ack = '0;
            ex_commit  = NO_EXC;
        end
    endtask

    // Drain the path, then read every slot written by the burst
    task automatic read_back();
        retire_rec_t rec;
        idle_cycles(8);
        expect_value("retire_count_o", retire_count, exp_order);
        while (exp_q.size() > 0) begin
            rec = exp_q.pop_front();
            @(negedge clk);
            rd_addr = rec.order[`RVFI_TRACE_AW-1:0];
            rd_exp  = rec;
            rd_vld  = 1'b1;
            reads++;
        end
        @(negedge clk);
        rd_vld = 1'b0;
        @(negedge clk);
    endtask

    a_order: assert property (@(posedge clk) disable iff (!arst_n)
        chk_vld |-> rd_rec.order == chk_exp.order)
        else report_mismatch("rd_rec_o.order", $sampled(rd_rec.order), $sampled(chk_exp.order));
    a_pc_rdata: assert property (@(posedge clk) disable iff (!arst_n)
        chk_vld |-> rd_rec.pc_rdata == chk_exp.pc_rdata)
        else report_mismatch("rd_rec_o.pc_rdata", $sampled(rd_rec.pc_rdata),
                             $sampled(chk_exp.pc_rdata));
    a_pc_wdata: assert property (@(posedge clk) disable iff (!arst_n)
        chk_vld |-> rd_rec.pc_wdata == chk_exp.pc_wdata)
        else report_mismatch("rd_rec_o.pc_wdata", $sampled(rd_rec.pc_wdata),
                             $sampled(chk_exp.pc_wdata));
    a_insn: assert property (@(posedge clk) disable iff (!arst_n)
        chk_vld |-> rd_rec.insn == chk_exp.insn)
        else report_mismatch("rd_rec_o.insn", $sampled(rd_rec.insn), $sampled(chk_exp.insn));
    a_rd_addr: assert property (@(posedge clk) disable iff (!arst_n)
        chk_vld |-> rd_rec.rd_addr == chk_exp.rd_addr)
        else report_mismatch("rd_rec_o.rd_addr", $sampled(rd_rec.rd_addr),
                             $sampled(chk_exp.rd_addr));
    a_rd_wdata: assert property (@(posedge clk) disable iff (!arst_n)
        chk_vld |-> rd_rec.rd_wdata == chk_exp.rd_wdata)
        else report_mismatch("rd_rec_o.rd_wdata", $sampled(rd_rec.rd_wdata),
                             $sampled(chk_exp.rd_wdata));
    a_trap: assert property (@(posedge clk) disable iff (!arst_n)
        chk_vld |-> rd_rec.trap == chk_exp.trap)
        else report_mismatch("rd_rec_o.trap", $sampled(rd_rec.trap), $sampled(chk_exp.trap));
    a_cause: assert property (@(posedge clk) disable iff (!arst_n)
        chk_vld |-> rd_rec.cause == chk_exp.cause)
        else report_mismatch("rd_rec_o.cause", $sampled(rd_rec.cause), $sampled(chk_exp.cause));
    a_priv: assert property (@(posedge clk) disable iff (!arst_n)
        chk_vld |-> rd_rec.priv == chk_exp.priv)
        else report_mismatch("rd_rec_o.priv", $sampled(rd_rec.priv), $sampled(chk_exp.priv));
    a_dbg: assert property (@(posedge clk) disable iff (!arst_n)
        chk_vld |-> rd_rec.dbg == chk_exp.dbg)
        else report_mismatch("rd_rec_o.dbg", $sampled(rd_rec.dbg), $sampled(chk_exp.dbg));

    initial begin
        lcg_state    = 32'h5dad;
        exp_order    = '0;
        arst_n       = 1'b0;
        commit_instr = '0;
        commit_ack   = '0;
        ex_commit    = NO_EXC;
        priv_lvl     = PRIV_MACHINE;
        debug_mode   = 1'b0;
        rd_addr      = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        expect_value("retire_count_o", retire_count, 32'h0);
        expect_value("overflow_o", overflow, 32'h0);

        // Single retires on port 0, then port 1
        commit_cycle(2'b01, rand_entry(0, 0), rand_entry(0, 0), NO_EXC, PRIV_MACHINE, 1'b0);
        commit_cycle(2'b10, rand_entry(0, 0), rand_entry(0, 0), NO_EXC, PRIV_MACHINE, 1'b0);
        read_back();

        // Dual retires
        repeat (3) begin
            commit_cycle(2'b11, rand_entry(0, 0), rand_entry(0, 0), NO_EXC, PRIV_MACHINE, 1'b0);
        end
        read_back();

        // Compressed words and writes to x0
        commit_cycle(2'b11, rand_entry(1, 0), rand_entry(0, 1), NO_EXC, PRIV_SUPERVISOR, 1'b1);
        commit_cycle(2'b01, rand_entry(1, 1), rand_entry(0, 0), NO_EXC, PRIV_SUPERVISOR, 1'b1);
        read_back();

        // Traps on port 0 plus an exception that port 1 must not take
        commit_cycle(2'b11, rand_entry(0, 0), rand_entry(0, 0), '{1'b1, 32'h2}, PRIV_USER, 1'b1);
        commit_cycle(2'b01, rand_entry(1, 0), rand_entry(0, 0), '{1'b1, next_rand()},
                     PRIV_MACHINE, 1'b0);
        commit_cycle(2'b10, rand_entry(0, 0), rand_entry(0, 0), '{1'b1, 32'hb},
                     PRIV_SUPERVISOR, 1'b0);
        read_back();
        expect_value("overflow_o", overflow, 32'h0);

        // Sustained dual retires outrun the single memory write port
        repeat (12) begin
            commit_cycle(2'b11, rand_entry(0, 0), rand_entry(0, 0), NO_EXC, PRIV_MACHINE, 1'b0);
        end
        idle_cycles(1);
        expect_value("overflow_o", overflow, 32'h1);
        idle_cycles(8);
        expect_value("overflow_o", overflow, 32'h1);
        expect_value("retire_count_o", retire_count, exp_order);
        exp_q.delete();

        $display("Checks done: %0d records read back, %0d errors", reads, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/rvfi_trace_top.sv */
// Retirement trace top level
// Probe collector, per-port tracers, write arbiter and trace memory
`timescale 1ns/10ps
`include "rvfi_trace_cfg.svh"
`default_nettype none

module rvfi_trace_top (
    input  logic                                               clk_i,
    input  logic                                               arst_n_i,
    input  rvfi_trace_pkg::commit_entry_t [`RVFI_NR_COMMIT-1:0] commit_instr_i,
    input  logic [`RVFI_NR_COMMIT-1:0]                         commit_ack_i,
    input  rvfi_trace_pkg::exception_t                         ex_commit_i,
    input  rvfi_trace_pkg::priv_lvl_t                          priv_lvl_i,
    input  logic                                               debug_mode_i,
    input  logic [`RVFI_TRACE_AW-1:0]                          rd_addr_i,
    output rvfi_trace_pkg::retire_rec_t                        rd_rec_o,
    output logic [`RVFI_ORDER_W-1:0]                           retire_count_o,
    output logic                                               overflow_o
);

    import rvfi_trace_pkg::*;

    rvfi_probes_t                      probes;
    logic [`RVFI_NR_COMMIT-1:0]        pending;
    logic [`RVFI_NR_COMMIT-1:0]        grant;
    logic [`RVFI_NR_COMMIT-1:0]        tracer_ovf;
    retire_rec_t [`RVFI_NR_COMMIT-1:0] tracer_rec;
    logic                              wr_en;
    logic [`RVFI_TRACE_AW-1:0]         wr_addr;
    retire_rec_t                       wr_rec;

    rvfi_probes u_probes (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .commit_instr_i (commit_instr_i),
        .commit_ack_i   (commit_ack_i),
        .ex_commit_i    (ex_commit_i),
        .priv_lvl_i     (priv_lvl_i),
        .debug_mode_i   (debug_mode_i),
        .probes_o       (probes),
        .retire_count_o (retire_count_o)
    );

    // One tracer per commit port
    for (genvar k = 0; k < `RVFI_NR_COMMIT; k++) begin : g_tracer
        rvfi_port_tracer u_tracer (
            .clk_i      (clk_i),
            .arst_n_i   (arst_n_i),
            .probe_i    (probes.port[k]),
            .grant_i    (grant[k]),
            .pending_o  (pending[k]),
            .rec_o      (tracer_rec[k]),
            .overflow_o (tracer_ovf[k])
        );
    end

    trace_write_arbiter u_arbiter (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .pending_i (pending),
        .rec_i     (tracer_rec),
        .grant_o   (grant),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .wr_rec_o  (wr_rec)
    );

    trace_buffer u_buffer (
        .clk_i     (clk_i),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_rec_i  (wr_rec),
        .rd_addr_i (rd_addr_i),
        .rd_rec_o  (rd_rec_o)
    );

    assign overflow_o = |tracer_ovf;

endmodule

`default_nettype wire

/* logic/trace_buffer.sv */
// Trace record memory
// One write port, registered read port, slots indexed by order number
`timescale 1ns/10ps
`include "rvfi_trace_cfg.svh"
`default_nettype none

module trace_buffer (
    input  logic                        clk_i,
    input  logic                        wr_en_i,
    input  logic [`RVFI_TRACE_AW-1:0]   wr_addr_i,
    input  rvfi_trace_pkg::retire_rec_t wr_rec_i,
    input  logic [`RVFI_TRACE_AW-1:0]   rd_addr_i,
    output rvfi_trace_pkg::retire_rec_t rd_rec_o
);

    import rvfi_trace_pkg::*;

    localparam int DEPTH = 1 << `RVFI_TRACE_AW;

    retire_rec_t mem_q [DEPTH];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_rec_i;
        end
    end

    // Same-slot read and write returns the old record
    always_ff @(posedge clk_i) begin
        rd_rec_o <= mem_q[rd_addr_i];
    end

endmodule

`default_nettype wire

/* logic/trace_write_arbiter.sv */
// Trace memory write arbiter
// Round-robin pick of one pending tracer per cycle, registered into a memory write
`timescale 1ns/10ps
`include "rvfi_trace_cfg.svh"
`default_nettype none

module trace_write_arbiter (
    input  logic                                             clk_i,
    input  logic                                             arst_n_i,
    input  logic [`RVFI_NR_COMMIT-1:0]                       pending_i,
    input  rvfi_trace_pkg::retire_rec_t [`RVFI_NR_COMMIT-1:0] rec_i,
    output logic [`RVFI_NR_COMMIT-1:0]                       grant_o,
    output logic                                             wr_en_o,
    output logic [`RVFI_TRACE_AW-1:0]                        wr_addr_o,
    output rvfi_trace_pkg::retire_rec_t                      wr_rec_o
);

    import rvfi_trace_pkg::*;

    localparam int NR = `RVFI_NR_COMMIT;
    localparam int PW = (NR > 1) ? $clog2(NR) : 1;

    logic [PW-1:0] last_q;
    logic [PW-1:0] win_idx;
    logic          win_any;
    int            cand;

    // Search starts just after the last granted tracer
    always_comb begin
        grant_o = '0;
        win_idx = last_q;
        win_any = 1'b0;
        cand    = 0;
        for (int k = 1; k <= NR; k++) begin
            cand = (int'(last_q) + k) % NR;
            if (!win_any && pending_i[cand]) begin
                win_any       = 1'b1;
                win_idx       = PW'(cand);
                grant_o[cand] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_q  <= PW'(NR - 1);
            wr_en_o <= 1'b0;
        end else begin
            wr_en_o <= win_any;
            if (win_any) begin
                last_q <= win_idx;
            end
        end
    end

    // Slot is the low bits of the order number
    always_ff @(posedge clk_i) begin
        wr_rec_o  <= rec_i[win_idx];
        wr_addr_o <= rec_i[win_idx].order[`RVFI_TRACE_AW-1:0];
    end

endmodule

`default_nettype wire

/* logic/rvfi_port_tracer.sv */
// Per-port retire tracer
// Builds retire records from one port's probes and queues them for the trace memory
`timescale 1ns/10ps
`include "rvfi_trace_cfg.svh"
`default_nettype none

module rvfi_port_tracer (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  rvfi_trace_pkg::port_probe_t probe_i,
    input  logic                        grant_i,
    output logic                        pending_o,
    output rvfi_trace_pkg::retire_rec_t rec_o,
    output logic                        overflow_o
);

    import rvfi_trace_pkg::*;

    localparam int QAW = (`RVFI_QDEPTH > 1) ? $clog2(`RVFI_QDEPTH) : 1;
    localparam logic [QAW:0] QFULL = `RVFI_QDEPTH;

    insn_word_u            raw_insn;
    insn_word_u            kept_insn;
    logic [`RVFI_XLEN-1:0] pc_step;
    retire_rec_t           new_rec;

    retire_rec_t    queue_q [`RVFI_QDEPTH];
    logic [QAW-1:0] wr_ptr_q;
    logic [QAW-1:0] rd_ptr_q;
    logic [QAW:0]   count_q;
    logic           full;
    logic           push;
    logic           pop;
    logic           overflow_q;

    always_comb begin
        raw_insn  = '0;
        kept_insn = '0;
        raw_insn.full = probe_i.insn;

        // Compressed encoding only keeps the lower half
        if (probe_i.is_compressed) begin
            kept_insn.comp.upper = '0;
            kept_insn.comp.lower = raw_insn.comp.lower;
            pc_step              = `RVFI_XLEN'(2);
        end else begin
            kept_insn.full = raw_insn.full;
            pc_step        = `RVFI_XLEN'(4);
        end

        new_rec          = '0;
        new_rec.order    = probe_i.order;
        new_rec.pc_rdata = probe_i.pc;
        new_rec.pc_wdata = probe_i.pc + pc_step;
        new_rec.insn     = kept_insn.full;
        new_rec.rd_addr  = probe_i.rd;
        new_rec.trap     = probe_i.trap;
        new_rec.cause    = probe_i.cause;
        new_rec.priv     = probe_i.priv;
        new_rec.dbg      = probe_i.dbg;

        // No architectural write for x0 or a trapped instruction
        if ((probe_i.rd == 5'd0) || probe_i.trap) begin
            new_rec.rd_wdata = '0;
        end else begin
            new_rec.rd_wdata = probe_i.result;
        end
    end

    assign full = (count_q == QFULL);
    assign pop  = grant_i && (count_q != '0);
    // A slot freed by this cycle's pop can take the new record
    assign push = probe_i.valid && (!full || pop);

    always_ff @(posedge clk_i) begin
        if (push) begin
            queue_q[wr_ptr_q] <= new_rec;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // Sticky until reset
            if (probe_i.valid && !push) begin
                overflow_q <= 1'b1;
            end
        end
    end

    assign pending_o  = (count_q != '0);
    assign rec_o      = queue_q[rd_ptr_q];
    assign overflow_o = overflow_q;

endmodule

`default_nettype wire

/* logic/rvfi_probes.sv */
// Commit probe collector
// Registers the commit ports into one snapshot and numbers retired instructions
`timescale 1ns/10ps
`include "rvfi_trace_cfg.svh"
`default_nettype none

module rvfi_probes (
    input  logic                                               clk_i,
    input  logic                                               arst_n_i,
    input  rvfi_trace_pkg::commit_entry_t [`RVFI_NR_COMMIT-1:0] commit_instr_i,
    input  logic [`RVFI_NR_COMMIT-1:0]                         commit_ack_i,
    input  rvfi_trace_pkg::exception_t                         ex_commit_i,
    input  rvfi_trace_pkg::priv_lvl_t                          priv_lvl_i,
    input  logic                                               debug_mode_i,
    output rvfi_trace_pkg::rvfi_probes_t                       probes_o,
    output logic [`RVFI_ORDER_W-1:0]                           retire_count_o
);

    import rvfi_trace_pkg::*;

    logic [`RVFI_ORDER_W-1:0] order_q;
    logic [`RVFI_ORDER_W-1:0] order_d;
    rvfi_probes_t             probes_d;
    rvfi_probes_t             probes_q;

    always_comb begin
        order_d  = order_q;
        probes_d = '0;

        // Acknowledged ports take consecutive numbers with port 0 first
        for (int i = 0; i < `RVFI_NR_COMMIT; i++) begin
            probes_d.port[i].valid         = commit_ack_i[i];
            probes_d.port[i].order         = order_d;
            probes_d.port[i].pc            = commit_instr_i[i].pc;
            probes_d.port[i].insn          = commit_instr_i[i].insn;
            probes_d.port[i].is_compressed = commit_instr_i[i].is_compressed;
            probes_d.port[i].rd            = commit_instr_i[i].rd;
            probes_d.port[i].result        = commit_instr_i[i].result;
            probes_d.port[i].priv          = priv_lvl_i;
            probes_d.port[i].dbg           = debug_mode_i;
            if (commit_ack_i[i]) begin
                order_d = order_d + `RVFI_ORDER_W'(1);
            end
        end

        // Commit exception only ever belongs to port 0
        probes_d.port[0].trap = commit_ack_i[0] & ex_commit_i.valid;
        if (probes_d.port[0].trap) begin
            probes_d.port[0].cause = ex_commit_i.cause;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            order_q  <= '0;
            probes_q <= '0;
        end else begin
            order_q  <= order_d;
            probes_q <= probes_d;
        end
    end

    assign probes_o       = probes_q;
    assign retire_count_o = order_q;

endmodule

`default_nettype wire

/* logic/rvfi_trace_pkg.sv */
// Retirement trace types
// Commit port, probe snapshot and retire record layouts
`include "rvfi_trace_cfg.svh"
`default_nettype none

package rvfi_trace_pkg;

    typedef enum logic [1:0] {
        PRIV_USER       = 2'b00,
        PRIV_SUPERVISOR = 2'b01,
        PRIV_MACHINE    = 2'b11
    } priv_lvl_t;

    // One commit port as the core presents it
    typedef struct packed {
        logic [`RVFI_XLEN-1:0] pc;
        logic [31:0]           insn;
        logic                  is_compressed;
        logic [4:0]            rd;
        logic [`RVFI_XLEN-1:0] result;
    } commit_entry_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] cause;
    } exception_t;

    // Instruction word with a full and a compressed view
    typedef union packed {
        logic [31:0] full;
        struct packed {
            logic [15:0] upper;
            logic [15:0] lower;
        } comp;
    } insn_word_u;

    typedef struct packed {
        logic                     valid;
        logic [`RVFI_ORDER_W-1:0] order;
        logic [`RVFI_XLEN-1:0]    pc;
        logic [31:0]              insn;
        logic                     is_compressed;
        logic [4:0]               rd;
        logic [`RVFI_XLEN-1:0]    result;
        logic                     trap;
        logic [31:0]              cause;
        priv_lvl_t                priv;
        logic                     dbg;
    } port_probe_t;

    typedef struct packed {
        port_probe_t [`RVFI_NR_COMMIT-1:0] port;
    } rvfi_probes_t;

    // One trace memory record
    typedef struct packed {
        logic [`RVFI_ORDER_W-1:0] order;
        logic [`RVFI_XLEN-1:0]    pc_rdata;
        logic [`RVFI_XLEN-1:0]    pc_wdata;
        logic [31:0]              insn;
        logic [4:0]               rd_addr;
        logic [`RVFI_XLEN-1:0]    rd_wdata;
        logic                     trap;
        logic [31:0]              cause;
        priv_lvl_t                priv;
        logic                     dbg;
    } retire_rec_t;

endpackage

`default_nettype wire

/* logic/rvfi_trace_cfg.svh */
// Retirement trace configuration
// Commit port count, widths and storage depths
`default_nettype none

`ifndef RVFI_TRACE_CFG_SVH
`define RVFI_TRACE_CFG_SVH

// Commit ports presented by the core each cycle
`define RVFI_NR_COMMIT 2

// Data and address width
`define RVFI_XLEN 32

// Trace memory address width for 16 records
`define RVFI_TRACE_AW 4

// Entries per tracer queue
`define RVFI_QDEPTH 4

// Retired instruction order counter
`define RVFI_ORDER_W 32

`endif

`default_nettype wire
